//--- logic/fetch_pkg.sv
package fetch_pkg;

	// default sizes, overridden through the top-level parameters
	localparam int BTB_INDEX_W = 6;
	localparam int QUEUE_DEPTH = 4;

	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] instr_t;

	// two instructions, slot 0 in the low word
	typedef logic [63:0] fetch_line_t;

	// index into the BTB, taken from pc[BTB_INDEX_W+1:2]
	typedef logic [BTB_INDEX_W-1:0] btb_index_t;

	// boot vector
	localparam vaddr_t RESET_PC = 32'hbfc0_0000;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;

	// function field of SPECIAL, instr[5:0]
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;

	// PC generator fetch state
	typedef enum logic {
		ST_RUN,
		ST_REPLAY
	} pc_state_e;

endpackage

//--- logic/fetch_if.sv
`timescale 1ns/1ps

// a redirect of the fetch stream, valid is a one-cycle strobe
interface redirect_if;
	logic              valid;
	fetch_pkg::vaddr_t pc;
	fetch_pkg::vaddr_t target;
	logic              taken;

	modport src (
		output valid, pc, target, taken
	);

	modport dst (
		input valid, pc, target, taken
	);
endinterface

// two instruction lanes, lane 0 holds the older one
interface fetch_pair_if;
	logic [1:0]              valid;
	fetch_pkg::vaddr_t [1:0] pc;
	fetch_pkg::instr_t [1:0] instr;
	logic [1:0]              pred_taken;
	fetch_pkg::vaddr_t [1:0] pred_target;

	// queue side of the write lanes
	modport push (
		input valid, pc, instr, pred_taken, pred_target
	);

	// queue side of the read lanes
	modport pop (
		output valid, pc, instr, pred_taken, pred_target
	);
endinterface

//--- logic/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
	input  logic              clk,
	input  logic              rst,
	input  logic              hold_i,
	redirect_if.dst           resolve,
	input  logic              resolve_mispredict_i,
	redirect_if.dst           presolve,
	input  logic              replay_valid_i,
	input  fetch_pkg::vaddr_t replay_pc_i,
	input  logic              predict_taken_i,
	input  fetch_pkg::vaddr_t predict_target_i,
	output fetch_pkg::vaddr_t pc_o,
	output logic              pc_valid_o
);

	fetch_pkg::vaddr_t    pc_q;
	fetch_pkg::vaddr_t    pc_d;
	logic                 valid_q;
	fetch_pkg::pc_state_e state_q;
	fetch_pkg::pc_state_e state_d;

	// redirects first, then stall, then prediction, then next pair
	always_comb begin
		pc_d    = pc_q;
		state_d = fetch_pkg::ST_RUN;
		if (resolve.valid && resolve_mispredict_i) begin
			pc_d = resolve.target;
		end else if (presolve.valid) begin
			pc_d = presolve.target;
		end else if (replay_valid_i) begin
			pc_d    = replay_pc_i;
			state_d = fetch_pkg::ST_REPLAY;
		end else if (hold_i || !valid_q) begin
			pc_d    = pc_q;
			state_d = state_q;
		end else if (predict_taken_i && state_q == fetch_pkg::ST_RUN) begin
			pc_d = predict_target_i;
		end else begin
			pc_d = {pc_q[31:3] + 29'd1, 3'b000};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q    <= fetch_pkg::RESET_PC;
			valid_q <= 1'b0;
			state_q <= fetch_pkg::ST_RUN;
		end else begin
			pc_q    <= pc_d;
			valid_q <= 1'b1;
			state_q <= state_d;
		end
	end

	assign pc_o       = pc_q;
	assign pc_valid_o = valid_q;

endmodule

//--- logic/btb_predictor.sv
`timescale 1ns/1ps

module btb_predictor #(
	parameter int BTB_INDEX_W = fetch_pkg::BTB_INDEX_W
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    hold_i,
	input  logic                    flush_i,
	input  fetch_pkg::vaddr_t       lookup_pc_i,
	redirect_if.dst                 update,
	output logic [1:0]              taken_o,
	output fetch_pkg::vaddr_t [1:0] target_o
);

	localparam int ENTRIES = 2 ** BTB_INDEX_W;
	// word address bits above the index
	localparam int TAG_W = 30 - BTB_INDEX_W;

	logic [ENTRIES-1:0]     valid_q;
	logic [TAG_W-1:0]       tag_mem [ENTRIES];
	fetch_pkg::vaddr_t      target_mem [ENTRIES];

	fetch_pkg::vaddr_t      slot_pc [2];
	logic [BTB_INDEX_W-1:0] rd_idx [2];
	logic [1:0]             hit;
	logic [BTB_INDEX_W-1:0] wr_idx;

	// both words of the aligned pair are looked up together
	always_comb begin
		slot_pc[0] = {lookup_pc_i[31:3], 3'b000};
		slot_pc[1] = {lookup_pc_i[31:3], 3'b100};
		for (int i = 0; i < 2; i++) begin
			rd_idx[i] = slot_pc[i][BTB_INDEX_W+1:2];
			hit[i]    = valid_q[rd_idx[i]]
				&& tag_mem[rd_idx[i]] == slot_pc[i][31:BTB_INDEX_W+2];
		end
	end

	// registered result lines up with the cache data in s2
	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			taken_o <= '0;
		end else if (!hold_i) begin
			taken_o <= hit;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			for (int i = 0; i < 2; i++) begin
				target_o[i] <= target_mem[rd_idx[i]];
			end
		end
	end

	assign wr_idx = update.pc[BTB_INDEX_W+1:2];

	// not-taken outcome drops the entry
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (update.valid) begin
			valid_q[wr_idx] <= update.taken;
		end
	end

	always_ff @(posedge clk) begin
		if (update.valid && update.taken) begin
			tag_mem[wr_idx]    <= update.pc[31:BTB_INDEX_W+2];
			target_mem[wr_idx] <= update.target;
		end
	end

endmodule

//--- logic/predecode.sv
`timescale 1ns/1ps

module predecode (
	input  fetch_pkg::instr_t instr_i,
	output logic              is_cf_o
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rt;
	logic       is_jump;
	logic       is_branch;
	logic       is_regimm_br;
	logic       is_jump_reg;

	assign opcode = instr_i[31:26];
	assign rt     = instr_i[20:16];
	assign funct  = instr_i[5:0];

	always_comb begin
		is_jump = opcode == fetch_pkg::OP_J
			|| opcode == fetch_pkg::OP_JAL;

		is_branch = opcode == fetch_pkg::OP_BEQ
			|| opcode == fetch_pkg::OP_BNE
			|| opcode == fetch_pkg::OP_BLEZ
			|| opcode == fetch_pkg::OP_BGTZ;

		// BLTZ, BGEZ, BLTZAL, BGEZAL are rt 0, 1, 16, 17
		is_regimm_br = opcode == fetch_pkg::OP_REGIMM
			&& rt[3:1] == 3'b000;

		is_jump_reg = opcode == fetch_pkg::OP_SPECIAL
			&& (funct == fetch_pkg::FN_JR || funct == fetch_pkg::FN_JALR);
	end

	assign is_cf_o = is_jump | is_branch | is_regimm_br | is_jump_reg;

endmodule

//--- logic/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
	parameter int DEPTH = fetch_pkg::QUEUE_DEPTH
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       flush_i,
	fetch_pair_if.push push,
	input  logic [1:0] push_num_i,
	output logic       full_o,
	fetch_pair_if.pop  pop,
	input  logic [1:0] pop_num_i
);

	localparam int CHANNELS = 4;
	localparam int SIZE     = CHANNELS * DEPTH;
	// low two pointer bits pick the channel, the rest the row
	localparam int PTR_W    = $clog2(SIZE);

	fetch_pkg::vaddr_t pc_mem     [CHANNELS][DEPTH];
	fetch_pkg::instr_t instr_mem  [CHANNELS][DEPTH];
	logic              taken_mem  [CHANNELS][DEPTH];
	fetch_pkg::vaddr_t target_mem [CHANNELS][DEPTH];

	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W:0]   count_q;
	logic [PTR_W-1:0] wr_ptr [2];
	logic [PTR_W-1:0] rd_ptr [2];
	logic [1:0]       push_acc;
	logic [1:0]       pop_cnt;

	assign full_o = count_q > (PTR_W+1)'(SIZE - 2);

	always_comb begin
		// a push while full is dropped as a whole
		push_acc = full_o ? 2'd0 : push_num_i;
		// never pop more than is shown valid
		if ((PTR_W+1)'(pop_num_i) > count_q) begin
			pop_cnt = count_q[1:0];
		end else begin
			pop_cnt = pop_num_i;
		end
		for (int i = 0; i < 2; i++) begin
			wr_ptr[i] = tail_q + PTR_W'(i);
			rd_ptr[i] = head_q + PTR_W'(i);
		end
	end

	// consecutive entries fall into different channels
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (push_acc > 2'(i) && push.valid[i]) begin
				pc_mem[wr_ptr[i][1:0]][wr_ptr[i][PTR_W-1:2]]     <= push.pc[i];
				instr_mem[wr_ptr[i][1:0]][wr_ptr[i][PTR_W-1:2]]  <= push.instr[i];
				taken_mem[wr_ptr[i][1:0]][wr_ptr[i][PTR_W-1:2]]  <= push.pred_taken[i];
				target_mem[wr_ptr[i][1:0]][wr_ptr[i][PTR_W-1:2]] <= push.pred_target[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			tail_q  <= tail_q + PTR_W'(push_acc);
			head_q  <= head_q + PTR_W'(pop_cnt);
			count_q <= count_q + (PTR_W+1)'(push_acc) - (PTR_W+1)'(pop_cnt);
		end
	end

	// oldest two entries, valid only where occupied
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			pop.valid[i]       = count_q > (PTR_W+1)'(i);
			pop.pc[i]          = pc_mem[rd_ptr[i][1:0]][rd_ptr[i][PTR_W-1:2]];
			pop.instr[i]       = instr_mem[rd_ptr[i][1:0]][rd_ptr[i][PTR_W-1:2]];
			pop.pred_taken[i]  = taken_mem[rd_ptr[i][1:0]][rd_ptr[i][PTR_W-1:2]];
			pop.pred_target[i] = target_mem[rd_ptr[i][1:0]][rd_ptr[i][PTR_W-1:2]];
		end
	end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter int BTB_INDEX_W = fetch_pkg::BTB_INDEX_W,
	parameter int QUEUE_DEPTH = fetch_pkg::QUEUE_DEPTH
) (
	input  logic                    clk,
	input  logic                    rst,
	output logic                    icache_read_o,
	output fetch_pkg::vaddr_t       icache_vaddr_o,
	input  fetch_pkg::fetch_line_t  icache_data_i,
	input  logic                    icache_stall_i,
	input  logic                    resolve_valid_i,
	input  logic                    resolve_mispredict_i,
	input  fetch_pkg::vaddr_t       resolve_pc_i,
	input  fetch_pkg::vaddr_t       resolve_target_i,
	input  logic                    resolve_taken_i,
	input  logic [1:0]              pop_num_i,
	output logic [1:0]              entry_valid_o,
	output fetch_pkg::vaddr_t [1:0] entry_pc_o,
	output fetch_pkg::instr_t [1:0] entry_instr_o,
	output logic [1:0]              entry_pred_taken_o,
	output fetch_pkg::vaddr_t [1:0] entry_pred_target_o
);

	redirect_if   bus_resolve ();
	redirect_if   bus_presolve ();
	fetch_pair_if bus_push ();
	fetch_pair_if bus_pop ();

	fetch_pkg::vaddr_t       pc_s1;
	logic                    pc_valid_s1;
	logic                    flush_s3;
	logic                    flush_s2;
	logic                    stall;
	logic                    presolve;
	logic                    replay;
	logic                    queue_full;
	logic                    s2_valid;
	fetch_pkg::vaddr_t       s2_pc;
	logic [1:0]              btb_taken;
	fetch_pkg::vaddr_t [1:0] btb_target;
	logic [1:0]              s2_slot_valid;
	logic [1:0]              s2_slot_taken;
	logic                    s2_redirect;
	fetch_pkg::vaddr_t       s2_redirect_target;
	logic [1:0]              s3_valid;
	logic [1:0]              s3_taken;
	fetch_pkg::vaddr_t [1:0] s3_pc;
	fetch_pkg::instr_t [1:0] s3_instr;
	fetch_pkg::vaddr_t [1:0] s3_target;
	logic [1:0]              s3_is_cf;
	logic [1:0]              s3_nocf;

	assign bus_resolve.valid  = resolve_valid_i;
	assign bus_resolve.pc     = resolve_pc_i;
	assign bus_resolve.target = resolve_target_i;
	assign bus_resolve.taken  = resolve_taken_i;

	// s3 acts only while the cache is not stalled
	assign flush_s3 = resolve_valid_i & resolve_mispredict_i;
	assign presolve = ~icache_stall_i & ~flush_s3 & ~queue_full & (|s3_nocf);
	assign replay   = ~icache_stall_i & ~flush_s3 & queue_full & (|s3_valid);
	assign flush_s2 = flush_s3 | presolve | replay;
	assign stall    = icache_stall_i & ~flush_s3;

	pc_gen u_pc_gen (
		.clk                  ( clk                  ),
		.rst                  ( rst                  ),
		.hold_i               ( stall                ),
		.resolve              ( bus_resolve          ),
		.resolve_mispredict_i ( resolve_mispredict_i ),
		.presolve             ( bus_presolve         ),
		.replay_valid_i       ( replay               ),
		.replay_pc_i          ( s3_pc[0]             ),
		.predict_taken_i      ( s2_redirect          ),
		.predict_target_i     ( s2_redirect_target   ),
		.pc_o                 ( pc_s1                ),
		.pc_valid_o           ( pc_valid_s1          )
	);

	btb_predictor #(
		.BTB_INDEX_W ( BTB_INDEX_W )
	) u_btb (
		.clk         ( clk         ),
		.rst         ( rst         ),
		.hold_i      ( stall       ),
		.flush_i     ( flush_s2    ),
		.lookup_pc_i ( pc_s1       ),
		.update      ( bus_resolve ),
		.taken_o     ( btb_taken   ),
		.target_o    ( btb_target  )
	);

	assign icache_read_o  = pc_valid_s1;
	assign icache_vaddr_o = {pc_s1[31:3], 3'b000};

	// the request behind a taken prediction is wrong path
	always_ff @(posedge clk) begin
		if (rst || flush_s2) begin
			s2_valid <= 1'b0;
		end else if (!stall) begin
			s2_valid <= pc_valid_s1 & ~s2_redirect;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s2_pc <= pc_s1;
		end
	end

	// slot 0 skipped on an odd-word entry, slot 1 dropped behind a taken slot 0
	always_comb begin
		s2_slot_valid[0]   = s2_valid & ~s2_pc[2];
		s2_slot_taken[0]   = s2_slot_valid[0] & btb_taken[0];
		s2_slot_valid[1]   = s2_valid & ~s2_slot_taken[0];
		s2_slot_taken[1]   = s2_slot_valid[1] & btb_taken[1];
		s2_redirect        = |s2_slot_taken;
		s2_redirect_target = s2_slot_taken[0] ? btb_target[0] : btb_target[1];
	end

	always_ff @(posedge clk) begin
		if (rst || flush_s2) begin
			s3_valid <= '0;
		end else if (!stall) begin
			s3_valid <= s2_slot_valid[0] ? s2_slot_valid : {1'b0, s2_slot_valid[1]};
		end
	end

	// compact into lane order while registering
	always_ff @(posedge clk) begin
		if (!stall) begin
			if (s2_slot_valid[0]) begin
				s3_pc[0]    <= {s2_pc[31:3], 3'b000};
				s3_pc[1]    <= {s2_pc[31:3], 3'b100};
				s3_instr[0] <= icache_data_i[31:0];
				s3_instr[1] <= icache_data_i[63:32];
				s3_taken    <= s2_slot_taken;
				s3_target   <= btb_target;
			end else begin
				s3_pc[0]     <= {s2_pc[31:3], 3'b100};
				s3_instr[0]  <= icache_data_i[63:32];
				s3_taken     <= {1'b0, s2_slot_taken[1]};
				s3_target[0] <= btb_target[1];
			end
		end
	end

	predecode u_predecode0 (
		.instr_i ( s3_instr[0] ),
		.is_cf_o ( s3_is_cf[0] )
	);

	predecode u_predecode1 (
		.instr_i ( s3_instr[1] ),
		.is_cf_o ( s3_is_cf[1] )
	);

	// prediction on a plain instruction, drop it and go on after the last lane
	assign s3_nocf = s3_valid & s3_taken & ~s3_is_cf;

	assign bus_presolve.valid  = presolve;
	assign bus_presolve.pc     = s3_nocf[0] ? s3_pc[0] : s3_pc[1];
	assign bus_presolve.target = (s3_valid[1] ? s3_pc[1] : s3_pc[0]) + 32'd4;
	assign bus_presolve.taken  = 1'b0;

	assign bus_push.valid       = s3_valid;
	assign bus_push.pc          = s3_pc;
	assign bus_push.instr       = s3_instr;
	assign bus_push.pred_taken  = s3_taken & ~s3_nocf;
	assign bus_push.pred_target = s3_target;

	instr_queue #(
		.DEPTH ( QUEUE_DEPTH )
	) u_queue (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.flush_i    ( flush_s3   ),
		.push       ( bus_push   ),
		.push_num_i ( (~icache_stall_i & ~flush_s3 & ~queue_full)
			? 2'(s3_valid[0]) + 2'(s3_valid[1]) : 2'd0 ),
		.full_o     ( queue_full ),
		.pop        ( bus_pop    ),
		.pop_num_i  ( pop_num_i  )
	);

	assign entry_valid_o       = bus_pop.valid;
	assign entry_pc_o          = bus_pop.pc;
	assign entry_instr_o       = bus_pop.instr;
	assign entry_pred_taken_o  = bus_pop.pred_taken;
	assign entry_pred_target_o = bus_pop.pred_target;

endmodule

//--- test/fetch_unit_props.sv
`timescale 1ns/1ps

module fetch_unit_props (
	input logic              clk,
	input logic              rst,
	input logic              queue_full_i,
	input logic              flush_i,
	input int                count_i,
	input logic [1:0]        entry_valid_i,
	input logic              resolve_valid_i,
	input logic              resolve_mispredict_i,
	input fetch_pkg::vaddr_t resolve_target_i,
	input logic              icache_read_i,
	input fetch_pkg::vaddr_t icache_vaddr_i
);

	// a full queue takes nothing, occupancy can only shrink
	assert property (@(posedge clk) disable iff (rst)
		queue_full_i && !flush_i
		|=> count_i <= $past(count_i))
	else $error("queue accepted a push while full");

	// lanes fill from lane 0
	assert property (@(posedge clk) disable iff (rst)
		entry_valid_i[1] |-> entry_valid_i[0])
	else $error("lane 1 shown valid while lane 0 is empty");

	assert property (@(posedge clk) disable iff (rst)
		resolve_valid_i && resolve_mispredict_i
		|=> icache_read_i && icache_vaddr_i == {$past(resolve_target_i[31:3]), 3'b000})
	else $error("request after a mispredict does not go to the resolved target");

endmodule

bind fetch_unit fetch_unit_props u_props (
	.clk                  ( clk                  ),
	.rst                  ( rst                  ),
	.queue_full_i         ( queue_full           ),
	.flush_i              ( flush_s3             ),
	.count_i              ( u_queue.count_q      ),
	.entry_valid_i        ( entry_valid_o        ),
	.resolve_valid_i      ( resolve_valid_i      ),
	.resolve_mispredict_i ( resolve_mispredict_i ),
	.resolve_target_i     ( resolve_target_i     ),
	.icache_read_i        ( icache_read_o        ),
	.icache_vaddr_i       ( icache_vaddr_o       )
);

//--- test/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

	localparam int SEQ_CYCLES   = 80;
	localparam int FILL_CYCLES  = 40;
	localparam int DRAIN_CYCLES = 120;
	localparam int REDIR_CYCLES = 40;
	localparam int TRAIN_CYCLES = 60;
	localparam int PRES_CYCLES  = 60;
	localparam int WAIT_LIMIT   = 30;
	// four redirects and two training cycles on top of the test bodies
	localparam int CYCLE_LIMIT  = SEQ_CYCLES + FILL_CYCLES + DRAIN_CYCLES + 2 * REDIR_CYCLES
		+ TRAIN_CYCLES + PRES_CYCLES + 4 * (WAIT_LIMIT + 1) + 2 + 20;

	localparam fetch_pkg::vaddr_t BNE_PC    = fetch_pkg::RESET_PC + 32'h048;
	localparam fetch_pkg::vaddr_t T_ALIGNED = fetch_pkg::RESET_PC + 32'h080;
	localparam fetch_pkg::vaddr_t J_PC      = fetch_pkg::RESET_PC + 32'h110;
	localparam fetch_pkg::vaddr_t T_ODD     = fetch_pkg::RESET_PC + 32'h1c4;
	localparam fetch_pkg::vaddr_t J_TGT     = fetch_pkg::RESET_PC + 32'h20c;
	localparam fetch_pkg::vaddr_t Q_PC      = fetch_pkg::RESET_PC + 32'h2a4;
	localparam fetch_pkg::vaddr_t Q_BAD     = fetch_pkg::RESET_PC + 32'h400;
	// resolve pc for plain redirects, its BTB index is never trained
	localparam fetch_pkg::vaddr_t REDIR_PC  = fetch_pkg::RESET_PC + 32'h03c;

	logic                    clk;
	logic                    rst;
	logic                    icache_read_o;
	fetch_pkg::vaddr_t       icache_vaddr_o;
	fetch_pkg::fetch_line_t  icache_data_i;
	logic                    icache_stall_i;
	logic                    resolve_valid_i;
	logic                    resolve_mispredict_i;
	fetch_pkg::vaddr_t       resolve_pc_i;
	fetch_pkg::vaddr_t       resolve_target_i;
	logic                    resolve_taken_i;
	logic [1:0]              pop_num_i;
	logic [1:0]              entry_valid_o;
	fetch_pkg::vaddr_t [1:0] entry_pc_o;
	fetch_pkg::instr_t [1:0] entry_instr_o;
	logic [1:0]              entry_pred_taken_o;
	fetch_pkg::vaddr_t [1:0] entry_pred_target_o;

	fetch_pkg::vaddr_t req_addr = fetch_pkg::RESET_PC;
	fetch_pkg::vaddr_t rom_addr = fetch_pkg::RESET_PC;
	logic              req_hold = 1'b0;
	logic [31:0]       lfsr;
	fetch_pkg::vaddr_t exp_next;
	fetch_pkg::vaddr_t trained [fetch_pkg::vaddr_t];
	int                cycle_cnt = 0;
	int                popped = 0;
	int                preds_seen = 0;
	int                corrected = 0;

	fetch_unit #(
		.BTB_INDEX_W ( fetch_pkg::BTB_INDEX_W ),
		.QUEUE_DEPTH ( fetch_pkg::QUEUE_DEPTH )
	) u_dut (
		.clk                  ( clk                  ),
		.rst                  ( rst                  ),
		.icache_read_o        ( icache_read_o        ),
		.icache_vaddr_o       ( icache_vaddr_o       ),
		.icache_data_i        ( icache_data_i        ),
		.icache_stall_i       ( icache_stall_i       ),
		.resolve_valid_i      ( resolve_valid_i      ),
		.resolve_mispredict_i ( resolve_mispredict_i ),
		.resolve_pc_i         ( resolve_pc_i         ),
		.resolve_target_i     ( resolve_target_i     ),
		.resolve_taken_i      ( resolve_taken_i      ),
		.pop_num_i            ( pop_num_i            ),
		.entry_valid_o        ( entry_valid_o        ),
		.entry_pc_o           ( entry_pc_o           ),
		.entry_instr_o        ( entry_instr_o        ),
		.entry_pred_taken_o   ( entry_pred_taken_o   ),
		.entry_pred_target_o  ( entry_pred_target_o  )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic fetch_pkg::instr_t rom_word(input fetch_pkg::vaddr_t a);
		if (a == J_PC) begin
			return {fetch_pkg::OP_J, J_TGT[27:2]};
		end
		if (a == BNE_PC) begin
			return {fetch_pkg::OP_BNE, 5'd1, 5'd2, 16'hfff0};
		end
		// addiu $1, $0 with the low address half
		return {6'h09, 5'd0, 5'd1, a[15:0]};
	endfunction

	function automatic logic is_jump_or_branch(input fetch_pkg::vaddr_t a);
		return a == J_PC || a == BNE_PC;
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// request seen mid-cycle, answered one cycle later unless stalled
	always @(negedge clk) begin
		req_addr = icache_vaddr_o;
		req_hold = icache_stall_i && !(resolve_valid_i && resolve_mispredict_i);
	end

	always @(posedge clk) begin
		#1;
		if (!req_hold) begin
			rom_addr = req_addr;
		end
		icache_data_i = {rom_word(rom_addr + 32'd4), rom_word(rom_addr)};
	end

	task automatic fail_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_vaddr(input string what, input fetch_pkg::vaddr_t got,
		input fetch_pkg::vaddr_t exp);
		if (got !== exp) begin
			$display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_instr(input string what, input fetch_pkg::instr_t got,
		input fetch_pkg::instr_t exp);
		if (got !== exp) begin
			$display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %0t ns: %s is %b, expected %b", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic draw_bits(input int n, output logic [1:0] v);
		v = 2'b00;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// one popped lane against the program order
	task automatic check_entry(input int lane);
		logic predicted;
		predicted = trained.exists(exp_next) && is_jump_or_branch(exp_next);
		check_vaddr("entry pc", entry_pc_o[lane], exp_next);
		check_instr("entry instr", entry_instr_o[lane], rom_word(exp_next));
		check_bit("entry pred_taken", entry_pred_taken_o[lane], predicted);
		if (trained.exists(exp_next) && !predicted) begin
			corrected++;
		end
		if (predicted) begin
			check_vaddr("entry pred_target", entry_pred_target_o[lane], trained[exp_next]);
			preds_seen++;
			exp_next = trained[exp_next];
		end else begin
			exp_next = exp_next + 32'd4;
		end
		popped++;
	endtask

	task automatic run_cycle(input logic [1:0] pops, input logic stall);
		for (int i = 0; i < 2; i++) begin
			if (i < int'(pops) && entry_valid_o[i]) begin
				check_entry(i);
			end
		end
		pop_num_i      = pops;
		icache_stall_i = stall;
		@(posedge clk);
		#1;
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("simulation ran past its limit of %0d cycles", CYCLE_LIMIT);
			fail_run();
		end
	endtask

	task automatic random_cycles(input int n, input logic use_stall);
		logic [1:0] pops;
		logic [1:0] st;
		for (int c = 0; c < n; c++) begin
			draw_bits(2, pops);
			if (pops == 2'd3) begin
				pops = 2'd2;
			end
			st = 2'b00;
			if (use_stall) begin
				draw_bits(2, st);
			end
			run_cycle(pops, &st);
		end
	endtask

	task automatic train_btb(input fetch_pkg::vaddr_t pc, input fetch_pkg::vaddr_t target);
		resolve_valid_i      = 1'b1;
		resolve_mispredict_i = 1'b0;
		resolve_pc_i         = pc;
		resolve_target_i     = target;
		resolve_taken_i      = 1'b1;
		run_cycle(2'd0, 1'b0);
		resolve_valid_i = 1'b0;
		trained[pc] = target;
	endtask

	task automatic redirect(input fetch_pkg::vaddr_t target);
		int waited;
		resolve_valid_i      = 1'b1;
		resolve_mispredict_i = 1'b1;
		resolve_pc_i         = REDIR_PC;
		resolve_target_i     = target;
		resolve_taken_i      = 1'b0;
		run_cycle(2'd0, 1'b0);
		resolve_valid_i      = 1'b0;
		resolve_mispredict_i = 1'b0;
		exp_next = target;
		waited = 0;
		while (entry_valid_o == 2'b00) begin
			if (waited == WAIT_LIMIT) begin
				$display("no entry arrived after a redirect to %h", target);
				fail_run();
			end
			run_cycle(2'd0, 1'b0);
			waited++;
		end
		// odd-word target leaves lane 1 empty in the first push
		check_bit("lane 1 of the first push", entry_valid_o[1], ~target[2]);
	endtask

	task automatic test_sequential();
		logic [1:0] st;
		check_bit("icache_read_o after reset", icache_read_o, 1'b0);
		check_bit("entry_valid_o after reset", |entry_valid_o, 1'b0);
		for (int c = 0; c < SEQ_CYCLES; c++) begin
			draw_bits(2, st);
			run_cycle(2'd2, &st);
		end
		if (popped < SEQ_CYCLES / 2) begin
			$display("sequential stream delivered only %0d entries", popped);
			fail_run();
		end
	endtask

	task automatic test_backpressure();
		int start;
		start = popped;
		for (int c = 0; c < FILL_CYCLES; c++) begin
			run_cycle(2'd0, 1'b0);
		end
		check_bit("lane 1 valid with a full queue", entry_valid_o[1], 1'b1);
		random_cycles(DRAIN_CYCLES, 1'b1);
		if (popped - start < DRAIN_CYCLES / 4) begin
			$display("stream stalled after the queue filled up");
			fail_run();
		end
	endtask

	task automatic test_redirect();
		redirect(T_ALIGNED);
		random_cycles(REDIR_CYCLES, 1'b1);
		redirect(T_ODD);
		random_cycles(REDIR_CYCLES, 1'b1);
	endtask

	task automatic test_training();
		int start;
		start = preds_seen;
		train_btb(J_PC, J_TGT);
		redirect(J_PC - 32'd8);
		random_cycles(TRAIN_CYCLES, 1'b1);
		if (preds_seen == start) begin
			$display("the trained jump was never delivered with a prediction");
			fail_run();
		end
	endtask

	task automatic test_presolve();
		int start;
		start = corrected;
		train_btb(Q_PC, Q_BAD);
		redirect(Q_PC - 32'd4);
		random_cycles(PRES_CYCLES, 1'b0);
		if (corrected == start) begin
			$display("the falsely predicted instruction was never delivered");
			fail_run();
		end
	endtask

	initial begin
		rst                  = 1'b1;
		icache_data_i        = '0;
		icache_stall_i       = 1'b0;
		resolve_valid_i      = 1'b0;
		resolve_mispredict_i = 1'b0;
		resolve_pc_i         = '0;
		resolve_target_i     = '0;
		resolve_taken_i      = 1'b0;
		pop_num_i            = 2'd0;
		lfsr                 = 32'd86874;
		exp_next             = fetch_pkg::RESET_PC;
		repeat (2) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
		test_sequential();
		test_backpressure();
		test_redirect();
		test_training();
		test_presolve();
		$display("all tests passed");
		$finish;
	end

endmodule

//--- files.f
logic/fetch_pkg.sv
logic/fetch_if.sv
logic/pc_gen.sv
logic/btb_predictor.sv
logic/predecode.sv
logic/instr_queue.sv
logic/fetch_unit.sv
test/fetch_unit_props.sv
test/fetch_unit_tb.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_if.sv
  - logic/pc_gen.sv
  - logic/btb_predictor.sv
  - logic/predecode.sv
  - logic/instr_queue.sv
  - logic/fetch_unit.sv
  - target: test
    files:
      - test/fetch_unit_props.sv
      - test/fetch_unit_tb.sv
